// File: verilog/accel_bus_pkg.sv
`default_nettype none

package accel_bus_pkg;

	// ----------------------------------------------------------
	// AHB-lite slave side
	// ----------------------------------------------------------
	localparam int HADDR_W = 32;
	localparam int HDATA_W = 32;

	typedef enum logic [1:0] {
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htrans_e;

	// Master to slave signals of one bus cycle
	// hready is the bus ready seen by every slave
	typedef struct packed {
		logic               hsel;
		logic               hready;
		htrans_e            htrans;
		logic               hwrite;
		logic [HADDR_W-1:0] haddr;
		logic [HDATA_W-1:0] hwdata;
	} ahb_req_t;

endpackage

`default_nettype wire

// File: verilog/accel_conv_pkg.sv
`default_nettype none

package accel_conv_pkg;

	// ----------------------------------------------------------
	// Data types
	// ----------------------------------------------------------
	typedef logic        [7:0]  pixel_t;
	typedef logic signed [7:0]  weight_t;
	typedef logic signed [15:0] bias_t;
	typedef logic signed [23:0] acc_t;

	localparam int N_TAPS = 9;
	typedef logic [3:0] tap_idx_t;

	localparam int DIM_W = 6;

	typedef struct packed {
		logic [DIM_W-1:0] width;
		logic [DIM_W-1:0] height;
		logic             act_linear;
		logic [3:0]       act_shift;
	} cfg_t;

	// Pixel is already zero for taps outside the image
	typedef struct packed {
		pixel_t   pixel;
		tap_idx_t idx;
		logic     last_of_frame;
	} tap_t;

	// ----------------------------------------------------------
	// Register map
	// ----------------------------------------------------------
	// Word index in haddr[5:2], element index from haddr[6] up
	typedef enum logic [3:0] {
		REG_DIM       = 4'd0,
		REG_LAYER_CFG = 4'd1,
		REG_START     = 4'd2,
		REG_DONE      = 4'd3,
		REG_PIXEL     = 4'd4,
		REG_WEIGHT    = 4'd5,
		REG_BIAS      = 4'd6
	} reg_idx_e;

	localparam int REG_IDX_LSB = 2;
	localparam int ELEM_LSB    = 6;

endpackage

`default_nettype wire

// File: verilog/vr_stage.sv
`timescale 1ns/1ps
`default_nettype none

module vr_stage #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rstn,
	input  payload_t in_i,
	input  logic     in_valid_i,
	output logic     in_ready_o,
	output payload_t out_o,
	output logic     out_valid_o,
	input  logic     out_ready_i
);
	logic     full_q;
	payload_t data_q;

	// Accepts a new word in the same cycle the old one leaves
	assign in_ready_o  = !full_q || out_ready_i;
	assign out_valid_o = full_q;
	assign out_o       = data_q;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			full_q <= 1'b0;
		end else if (in_ready_o) begin
			full_q <= in_valid_i;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid_i && in_ready_o) begin
			data_q <= in_i;
		end
	end

	a_hold: assert property (@(posedge clk) disable iff (!rstn)
		(out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_o)));

endmodule

`default_nettype wire

// File: verilog/ahb_reg_slave.sv
`timescale 1ns/1ps
`default_nettype none

module ahb_reg_slave #(
	parameter int MAX_DIM = 32,
	parameter int N_CH    = 2
) (
	input  logic                                     clk,
	input  logic                                     rstn,
	input  accel_bus_pkg::ahb_req_t                  ahb_req_i,
	output logic [accel_bus_pkg::HDATA_W-1:0]        hrdata_o,
	output accel_conv_pkg::cfg_t                     cfg_o,
	output accel_conv_pkg::weight_t [N_CH*accel_conv_pkg::N_TAPS-1:0] weights_o,
	output accel_conv_pkg::bias_t [N_CH-1:0]         biases_o,
	output logic                                     start_o,
	output logic                                     pix_we_o,
	output logic [$clog2(MAX_DIM*MAX_DIM)-1:0]       pix_addr_o,
	output accel_conv_pkg::pixel_t                   pix_data_o,
	input  logic                                     frame_done_i
);
	import accel_bus_pkg::*;
	import accel_conv_pkg::*;

	localparam int PIX_AW = $clog2(MAX_DIM * MAX_DIM);
	localparam int ELEM_W = HADDR_W - ELEM_LSB;

	logic                                take;
	logic                                wr_q;
	reg_idx_e                            idx_q;
	logic [ELEM_W-1:0]                   elem_q;
	cfg_t                                cfg_q;
	logic                                done_q;
	weight_t [N_CH*N_TAPS-1:0]           weights_q;
	bias_t [N_CH-1:0]                    biases_q;

	// ----------------------------------------------------------
	// Address phase
	// ----------------------------------------------------------
	assign take = ahb_req_i.hsel && ahb_req_i.hready &&
		(ahb_req_i.htrans == NONSEQ || ahb_req_i.htrans == SEQ);

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			wr_q   <= 1'b0;
			idx_q  <= REG_DIM;
			elem_q <= '0;
		end else begin
			wr_q <= take && ahb_req_i.hwrite;
			if (take) begin
				idx_q  <= reg_idx_e'(ahb_req_i.haddr[REG_IDX_LSB +: 4]);
				elem_q <= ahb_req_i.haddr[HADDR_W-1:ELEM_LSB];
			end
		end
	end

	// ----------------------------------------------------------
	// Data phase
	// ----------------------------------------------------------
	assign start_o    = wr_q && (idx_q == REG_START) && ahb_req_i.hwdata[0];
	assign pix_we_o   = wr_q && (idx_q == REG_PIXEL);
	assign pix_addr_o = elem_q[PIX_AW-1:0];
	assign pix_data_o = ahb_req_i.hwdata[7:0];

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			cfg_q  <= '0;
			done_q <= 1'b0;
		end else begin
			if (wr_q && idx_q == REG_DIM) begin
				cfg_q.width  <= ahb_req_i.hwdata[DIM_W-1:0];
				cfg_q.height <= ahb_req_i.hwdata[8 +: DIM_W];
			end
			if (wr_q && idx_q == REG_LAYER_CFG) begin
				cfg_q.act_linear <= ahb_req_i.hwdata[0];
				cfg_q.act_shift  <= ahb_req_i.hwdata[4:1];
			end
			// START wins over a finishing frame
			if (start_o) begin
				done_q <= 1'b0;
			end else if (frame_done_i) begin
				done_q <= 1'b1;
			end
		end
	end

	// Weight index is channel*9 + tap
	always_ff @(posedge clk) begin
		if (wr_q && idx_q == REG_WEIGHT && elem_q < N_CH * N_TAPS) begin
			weights_q[elem_q] <= ahb_req_i.hwdata[7:0];
		end
		if (wr_q && idx_q == REG_BIAS && elem_q < N_CH) begin
			biases_q[elem_q] <= ahb_req_i.hwdata[15:0];
		end
	end

	assign cfg_o     = cfg_q;
	assign weights_o = weights_q;
	assign biases_o  = biases_q;

	// Readback in the same bit layout as the writes
	always_comb begin
		hrdata_o = '0;
		case (idx_q)
			REG_DIM: begin
				hrdata_o[DIM_W-1:0]  = cfg_q.width;
				hrdata_o[8 +: DIM_W] = cfg_q.height;
			end
			REG_LAYER_CFG: hrdata_o[4:0] = {cfg_q.act_shift, cfg_q.act_linear};
			REG_DONE:      hrdata_o[0] = done_q;
			REG_WEIGHT: begin
				if (elem_q < N_CH * N_TAPS) begin
					hrdata_o[7:0] = weights_q[elem_q];
				end
			end
			REG_BIAS: begin
				if (elem_q < N_CH) begin
					hrdata_o[15:0] = biases_q[elem_q];
				end
			end
			default: hrdata_o = '0;
		endcase
	end

	// Software must not address a channel beyond N_CH
	a_weight_ch: assert property (@(posedge clk) disable iff (!rstn)
		(wr_q && idx_q == REG_WEIGHT) |-> (elem_q < N_CH * N_TAPS));

endmodule

`default_nettype wire

// File: verilog/window_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module window_fetch #(
	parameter int MAX_DIM = 32
) (
	input  logic                               clk,
	input  logic                               rstn,
	input  accel_conv_pkg::cfg_t               cfg_i,
	input  logic                               start_i,
	input  logic                               pix_we_i,
	input  logic [$clog2(MAX_DIM*MAX_DIM)-1:0] pix_addr_i,
	input  accel_conv_pkg::pixel_t             pix_data_i,
	output accel_conv_pkg::tap_t               tap_o,
	output logic                               tap_valid_o,
	input  logic                               tap_ready_i
);
	import accel_conv_pkg::*;

	localparam int PIX_AW = $clog2(MAX_DIM * MAX_DIM);

	// Image stored linearly, pixel (row, col) at row*width + col
	pixel_t            mem [MAX_DIM*MAX_DIM];

	logic              running_q;
	logic              valid_q;
	logic [DIM_W-1:0]  row_q;
	logic [DIM_W-1:0]  col_q;
	tap_idx_t          tap_q;
	logic [PIX_AW-1:0] base_q;

	pixel_t            rdata_q;
	tap_idx_t          idx_q;
	logic              zero_q;
	logic              last_q;

	logic              first_row;
	logic              last_row;
	logic              first_col;
	logic              last_col;
	logic              up;
	logic              down;
	logic              left;
	logic              right;
	logic              outside;
	logic              issue;
	logic [PIX_AW-1:0] w_ext;
	logic [PIX_AW-1:0] rd_addr;

	assign first_row = (row_q == '0);
	assign last_row  = (row_q == cfg_i.height - 1'b1);
	assign first_col = (col_q == '0);
	assign last_col  = (col_q == cfg_i.width - 1'b1);
	assign w_ext     = PIX_AW'(cfg_i.width);

	// Next tap goes out when the output slot is free or draining
	assign issue = running_q && (!valid_q || tap_ready_i);

	// ----------------------------------------------------------
	// Neighbor address and border tests
	// ----------------------------------------------------------
	always_comb begin
		up    = (tap_q == 4'd0) || (tap_q == 4'd1) || (tap_q == 4'd2);
		down  = (tap_q == 4'd6) || (tap_q == 4'd7) || (tap_q == 4'd8);
		left  = (tap_q == 4'd0) || (tap_q == 4'd3) || (tap_q == 4'd6);
		right = (tap_q == 4'd2) || (tap_q == 4'd5) || (tap_q == 4'd8);
		outside = (up & first_row) | (down & last_row) |
			(left & first_col) | (right & last_col);
		rd_addr = base_q;
		if (up) begin
			rd_addr = rd_addr - w_ext;
		end
		if (down) begin
			rd_addr = rd_addr + w_ext;
		end
		if (left) begin
			rd_addr = rd_addr - 1'b1;
		end
		if (right) begin
			rd_addr = rd_addr + 1'b1;
		end
	end

	// ----------------------------------------------------------
	// Scan counters
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			running_q <= 1'b0;
			valid_q   <= 1'b0;
			row_q     <= '0;
			col_q     <= '0;
			tap_q     <= '0;
			base_q    <= '0;
		end else begin
			if (start_i && !running_q) begin
				running_q <= 1'b1;
				row_q     <= '0;
				col_q     <= '0;
				tap_q     <= '0;
				base_q    <= '0;
			end else if (issue) begin
				if (tap_q == N_TAPS - 1) begin
					tap_q  <= '0;
					base_q <= base_q + 1'b1;
					if (last_col) begin
						col_q <= '0;
						row_q <= row_q + 1'b1;
						if (last_row) begin
							running_q <= 1'b0;
						end
					end else begin
						col_q <= col_q + 1'b1;
					end
				end else begin
					tap_q <= tap_q + 1'b1;
				end
			end
			if (issue) begin
				valid_q <= 1'b1;
			end else if (tap_ready_i) begin
				valid_q <= 1'b0;
			end
		end
	end

	// Synchronous read, held while the output stalls
	always_ff @(posedge clk) begin
		if (pix_we_i) begin
			mem[pix_addr_i] <= pix_data_i;
		end
		if (issue) begin
			rdata_q <= mem[rd_addr];
			idx_q   <= tap_q;
			zero_q  <= outside;
			last_q  <= (tap_q == N_TAPS - 1) && last_row && last_col;
		end
	end

	always_comb begin
		tap_o.pixel         = zero_q ? '0 : rdata_q;
		tap_o.idx           = idx_q;
		tap_o.last_of_frame = last_q;
	end

	assign tap_valid_o = valid_q;

	a_tap_range: assert property (@(posedge clk) disable iff (!rstn)
		running_q |-> (tap_q < N_TAPS));

endmodule

`default_nettype wire

// File: verilog/conv3x3_mac.sv
`timescale 1ns/1ps
`default_nettype none

module conv3x3_mac #(
	parameter int N_CH = 2
) (
	input  logic                                         clk,
	input  logic                                         rstn,
	input  accel_conv_pkg::cfg_t                         cfg_i,
	input  accel_conv_pkg::weight_t [N_CH*accel_conv_pkg::N_TAPS-1:0] weights_i,
	input  accel_conv_pkg::bias_t [N_CH-1:0]             biases_i,
	input  accel_conv_pkg::tap_t                         tap_i,
	input  logic                                         tap_valid_i,
	output logic                                         tap_ready_o,
	output logic [N_CH*$bits(accel_conv_pkg::pixel_t):0] res_o,
	output logic                                         res_valid_o,
	input  logic                                         res_ready_i
);
	import accel_conv_pkg::*;

	acc_t              acc_q [N_CH];
	acc_t              acc_next [N_CH];
	pixel_t [N_CH-1:0] pix_q;
	logic              last_q;
	logic              valid_q;
	logic              tap_fire;
	logic              tap_last;

	// Shift, then ReLU to 0..255 or linear to -128..127
	function automatic pixel_t activate(acc_t v, cfg_t cfg);
		acc_t s;
		s = v >>> cfg.act_shift;
		if (!cfg.act_linear) begin
			if (s < 0) begin
				return 8'd0;
			end else if (s > 255) begin
				return 8'd255;
			end
		end else begin
			if (s < -128) begin
				return 8'h80;
			end else if (s > 127) begin
				return 8'h7f;
			end
		end
		return s[7:0];
	endfunction

	// No new taps while an unaccepted result sits here
	assign tap_ready_o = !valid_q || res_ready_i;
	assign tap_fire    = tap_valid_i && tap_ready_o;
	assign tap_last    = (tap_i.idx == N_TAPS - 1);

	// Tap 0 seeds the sum with the bias
	always_comb begin
		for (int ch = 0; ch < N_CH; ch++) begin
			acc_next[ch] = ((tap_i.idx == '0) ? acc_t'(biases_i[ch]) : acc_q[ch]) +
				$signed({1'b0, tap_i.pixel}) * weights_i[ch * N_TAPS + tap_i.idx];
		end
	end

	always_ff @(posedge clk) begin
		if (tap_fire) begin
			for (int ch = 0; ch < N_CH; ch++) begin
				acc_q[ch] <= acc_next[ch];
				if (tap_last) begin
					pix_q[ch] <= activate(acc_next[ch], cfg_i);
				end
			end
			if (tap_last) begin
				last_q <= tap_i.last_of_frame;
			end
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			valid_q <= 1'b0;
		end else if (tap_fire && tap_last) begin
			valid_q <= 1'b1;
		end else if (res_ready_i) begin
			valid_q <= 1'b0;
		end
	end

	// Pixels above, frame flag in bit 0
	assign res_o       = {pix_q, last_q};
	assign res_valid_o = valid_q;

endmodule

`default_nettype wire

// File: verilog/cnn_accel_top.sv
`timescale 1ns/1ps
`default_nettype none

module cnn_accel_top #(
	parameter int MAX_DIM = 32,
	parameter int N_CH    = 2
) (
	input  logic                              clk,
	input  logic                              rstn,
	input  accel_bus_pkg::ahb_req_t           ahb_req_i,
	output logic [accel_bus_pkg::HDATA_W-1:0] hrdata_o,
	output accel_conv_pkg::pixel_t [N_CH-1:0] result_o,
	output logic                              result_valid_o,
	input  logic                              result_ready_i
);
	import accel_conv_pkg::*;

	localparam int PIX_AW = $clog2(MAX_DIM * MAX_DIM);

	// Same bit layout as the MAC result vector
	typedef struct packed {
		pixel_t [N_CH-1:0] pix;
		logic              last_of_frame;
	} res_t;

	cfg_t                      cfg;
	weight_t [N_CH*N_TAPS-1:0] weights;
	bias_t [N_CH-1:0]          biases;
	logic                      start;
	logic                      pix_we;
	logic [PIX_AW-1:0]         pix_addr;
	pixel_t                    pix_data;
	logic                      frame_done;

	tap_t                      fetch_tap;
	logic                      fetch_valid;
	logic                      fetch_ready;
	tap_t                      mac_tap;
	logic                      mac_tap_valid;
	logic                      mac_tap_ready;
	res_t                      mac_res;
	logic                      mac_res_valid;
	logic                      mac_res_ready;
	res_t                      out_res;

	assign result_o   = out_res.pix;
	assign frame_done = result_valid_o && result_ready_i && out_res.last_of_frame;

	ahb_reg_slave #(
		.MAX_DIM(MAX_DIM),
		.N_CH   (N_CH)
	) u_slave (
		.clk         (clk),
		.rstn        (rstn),
		.ahb_req_i   (ahb_req_i),
		.hrdata_o    (hrdata_o),
		.cfg_o       (cfg),
		.weights_o   (weights),
		.biases_o    (biases),
		.start_o     (start),
		.pix_we_o    (pix_we),
		.pix_addr_o  (pix_addr),
		.pix_data_o  (pix_data),
		.frame_done_i(frame_done)
	);

	window_fetch #(
		.MAX_DIM(MAX_DIM)
	) u_fetch (
		.clk        (clk),
		.rstn       (rstn),
		.cfg_i      (cfg),
		.start_i    (start),
		.pix_we_i   (pix_we),
		.pix_addr_i (pix_addr),
		.pix_data_i (pix_data),
		.tap_o      (fetch_tap),
		.tap_valid_o(fetch_valid),
		.tap_ready_i(fetch_ready)
	);

	vr_stage #(
		.payload_t(tap_t)
	) u_tap_stage (
		.clk        (clk),
		.rstn       (rstn),
		.in_i       (fetch_tap),
		.in_valid_i (fetch_valid),
		.in_ready_o (fetch_ready),
		.out_o      (mac_tap),
		.out_valid_o(mac_tap_valid),
		.out_ready_i(mac_tap_ready)
	);

	conv3x3_mac #(
		.N_CH(N_CH)
	) u_mac (
		.clk        (clk),
		.rstn       (rstn),
		.cfg_i      (cfg),
		.weights_i  (weights),
		.biases_i   (biases),
		.tap_i      (mac_tap),
		.tap_valid_i(mac_tap_valid),
		.tap_ready_o(mac_tap_ready),
		.res_o      (mac_res),
		.res_valid_o(mac_res_valid),
		.res_ready_i(mac_res_ready)
	);

	vr_stage #(
		.payload_t(res_t)
	) u_res_stage (
		.clk        (clk),
		.rstn       (rstn),
		.in_i       (mac_res),
		.in_valid_i (mac_res_valid),
		.in_ready_o (mac_res_ready),
		.out_o      (out_res),
		.out_valid_o(result_valid_o),
		.out_ready_i(result_ready_i)
	);

endmodule

`default_nettype wire

// File: test/conv_checker.sv
`timescale 1ns/1ps
`default_nettype none

module conv_checker #(
	parameter int MAX_DIM = 32,
	parameter int N_CH    = 2
) (
	input  logic                    clk,
	input  logic                    rstn,
	input  accel_bus_pkg::ahb_req_t ahb_req_i,
	input  logic [N_CH*8-1:0]       result_i,
	input  logic                    result_valid_i,
	input  logic                    result_ready_i,
	output int                      compared_o,
	output int                      value_errors_o,
	output int                      other_errors_o,
	output int                      pending_o
);
	import accel_bus_pkg::*;
	import accel_conv_pkg::*;

	// Shadow of the register file, rebuilt from bus writes
	int                width_m;
	int                height_m;
	int                linear_m;
	int                shift_m;
	int                img_m [MAX_DIM*MAX_DIM];
	int                weight_m [N_CH*N_TAPS];
	int                bias_m [N_CH];

	logic [N_CH*8-1:0] expect_q [$];
	bit                wr_pend;
	logic [3:0]        idx_l;
	int                elem_l;
	int                pix_seen;

	// ----------------------------------------------------------
	// Reference model
	// ----------------------------------------------------------
	function automatic int expect_pixel(int r, int c, int ch);
		int acc;
		int rr;
		int cc;
		int p;
		acc = bias_m[ch];
		for (int t = 0; t < N_TAPS; t++) begin
			rr = r + t / 3 - 1;
			cc = c + t % 3 - 1;
			p = 0;
			// Zero padding outside the image
			if (rr >= 0 && rr < height_m && cc >= 0 && cc < width_m) begin
				p = img_m[rr * width_m + cc];
			end
			acc = acc + p * weight_m[ch * N_TAPS + t];
		end
		acc = acc >>> shift_m;
		if (linear_m != 0) begin
			acc = (acc > 127) ? 127 : ((acc < -128) ? -128 : acc);
			return acc & 255;
		end
		return (acc > 255) ? 255 : ((acc < 0) ? 0 : acc);
	endfunction

	task automatic build_frame();
		logic [N_CH*8-1:0] v;
		v = '0;
		for (int r = 0; r < height_m; r++) begin
			for (int c = 0; c < width_m; c++) begin
				for (int ch = 0; ch < N_CH; ch++) begin
					v[ch*8 +: 8] = 8'(expect_pixel(r, c, ch));
				end
				expect_q.push_back(v);
			end
		end
		pix_seen = 0;
	endtask

	task automatic apply_write(input logic [3:0] idx, input int elem, input logic [31:0] d);
		case (idx)
			REG_DIM: begin
				width_m  = int'(d[5:0]);
				height_m = int'(d[13:8]);
			end
			REG_LAYER_CFG: begin
				linear_m = int'(d[0]);
				shift_m  = int'(d[4:1]);
			end
			REG_START: if (d[0] && expect_q.size() == 0) build_frame();
			REG_PIXEL: if (elem < MAX_DIM * MAX_DIM) img_m[elem] = int'(d[7:0]);
			REG_WEIGHT: if (elem < N_CH * N_TAPS) weight_m[elem] = int'($signed(d[7:0]));
			REG_BIAS: if (elem < N_CH) bias_m[elem] = int'($signed(d[15:0]));
			default: ;
		endcase
	endtask

	task automatic compare_result();
		logic [N_CH*8-1:0] exp;
		if (expect_q.size() == 0) begin
			other_errors_o++;
			$display("Unexpected result %h at %0t with no frame pending", result_i, $time);
		end else begin
			exp = expect_q.pop_front();
			compared_o++;
			if (result_i !== exp) begin
				value_errors_o++;
				$display("ERR %0t: result %0d is %h, expected %h",
					$time, pix_seen, result_i, exp);
			end
			pix_seen++;
		end
	endtask

	// ----------------------------------------------------------
	// Bus snoop and output compare
	// ----------------------------------------------------------
	always @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			wr_pend        = 1'b0;
			idx_l          = '0;
			elem_l         = 0;
			compared_o     = 0;
			value_errors_o = 0;
			other_errors_o = 0;
			pending_o      = 0;
		end else begin
			// Data phase of the previous transfer first
			if (wr_pend) begin
				apply_write(idx_l, elem_l, ahb_req_i.hwdata);
			end
			wr_pend = 1'b0;
			if (ahb_req_i.hsel && ahb_req_i.hready &&
				(ahb_req_i.htrans == NONSEQ || ahb_req_i.htrans == SEQ)) begin
				wr_pend = ahb_req_i.hwrite;
				idx_l   = ahb_req_i.haddr[5:2];
				elem_l  = int'(ahb_req_i.haddr[31:6]);
			end
			if (result_valid_i && result_ready_i) begin
				compare_result();
			end
			pending_o = expect_q.size();
		end
	end

endmodule

`default_nettype wire

// File: test/tb_cnn_accel.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cnn_accel;
	import accel_bus_pkg::*;
	import accel_conv_pkg::*;

	localparam int MAX_DIM    = 32;
	localparam int N_CH       = 2;
	localparam int POLL_LIMIT = 4000;

	logic               clk = 1'b0;
	logic               rstn = 1'b0;
	ahb_req_t           ahb_req = '0;
	logic [HDATA_W-1:0] hrdata;
	logic [N_CH*8-1:0]  result;
	logic               result_valid;
	logic               result_ready = 1'b0;
	logic               random_ready = 1'b0;
	logic [31:0]        rng = 32'd89;
	logic [31:0]        ready_rng = 32'd89 ^ 32'h5a5a_5a5a;
	int                 tb_value_errors = 0;
	int                 tb_other_errors = 0;
	int                 total_pixels = 0;
	bit                 timed_out = 1'b0;
	int                 compared;
	int                 value_errors;
	int                 other_errors;
	int                 pending;

	always #4 clk = ~clk;

	cnn_accel_top #(
		.MAX_DIM(MAX_DIM),
		.N_CH   (N_CH)
	) uut (
		.clk           (clk),
		.rstn          (rstn),
		.ahb_req_i     (ahb_req),
		.hrdata_o      (hrdata),
		.result_o      (result),
		.result_valid_o(result_valid),
		.result_ready_i(result_ready)
	);

	conv_checker #(
		.MAX_DIM(MAX_DIM),
		.N_CH   (N_CH)
	) u_checker (
		.clk           (clk),
		.rstn          (rstn),
		.ahb_req_i     (ahb_req),
		.result_i      (result),
		.result_valid_i(result_valid),
		.result_ready_i(result_ready),
		.compared_o    (compared),
		.value_errors_o(value_errors),
		.other_errors_o(other_errors),
		.pending_o     (pending)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] rand_word();
		rng = xorshift32(rng);
		return rng;
	endfunction

	// Output back-pressure, about three cycles in four ready
	always @(negedge clk) begin
		if (random_ready) begin
			ready_rng = xorshift32(ready_rng);
			result_ready <= ready_rng[0] | ready_rng[1];
		end else begin
			result_ready <= 1'b1;
		end
	end

	// ----------------------------------------------------------
	// AHB-lite transfers
	// ----------------------------------------------------------
	function automatic logic [31:0] reg_addr(reg_idx_e idx, int elem);
		return (32'(elem) << ELEM_LSB) | (32'(idx) << REG_IDX_LSB);
	endfunction

	task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
		@(negedge clk);
		ahb_req.hsel   = 1'b1;
		ahb_req.hready = 1'b1;
		ahb_req.htrans = NONSEQ;
		ahb_req.hwrite = 1'b1;
		ahb_req.haddr  = addr;
		@(negedge clk);
		ahb_req.hsel   = 1'b0;
		ahb_req.htrans = IDLE;
		ahb_req.hwdata = data;
	endtask

	task automatic read_reg(input logic [31:0] addr, output logic [31:0] data);
		@(negedge clk);
		ahb_req.hsel   = 1'b1;
		ahb_req.hready = 1'b1;
		ahb_req.htrans = NONSEQ;
		ahb_req.hwrite = 1'b0;
		ahb_req.haddr  = addr;
		@(negedge clk);
		ahb_req.hsel   = 1'b0;
		ahb_req.htrans = IDLE;
		data = hrdata;
	endtask

	task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			tb_value_errors++;
			$display("ERR %0t: %s read %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic wait_done();
		logic [31:0] rd;
		int          polls;
		rd = '0;
		polls = 0;
		while (rd[0] !== 1'b1 && polls < POLL_LIMIT) begin
			read_reg(reg_addr(REG_DONE, 0), rd);
			polls++;
		end
		if (rd[0] !== 1'b1) begin
			timed_out = 1'b1;
			tb_other_errors++;
			$display("Timeout: DONE never set, %0d results still expected", pending);
		end else if (pending != 0) begin
			tb_other_errors++;
			$display("DONE set while %0d results were still expected", pending);
		end
	endtask

	// ----------------------------------------------------------
	// One layer: config, image, weights, biases, START, DONE
	// ----------------------------------------------------------
	task automatic run_frame(input int w, input int h, input bit linear, input int shift,
		input bit big_weights, input bit rand_rdy);
		logic [31:0] r;
		logic [31:0] rd;
		int          wv;
		if (!timed_out) begin
			random_ready = rand_rdy;
			total_pixels += w * h;
			write_reg(reg_addr(REG_DIM, 0), 32'(w) | (32'(h) << 8));
			write_reg(reg_addr(REG_LAYER_CFG, 0), 32'(shift << 1) | 32'(linear));
			read_reg(reg_addr(REG_DIM, 0), rd);
			check_word("REG_DIM", rd, 32'(w) | (32'(h) << 8));
			read_reg(reg_addr(REG_LAYER_CFG, 0), rd);
			check_word("REG_LAYER_CFG", rd, 32'(shift << 1) | 32'(linear));
			for (int p = 0; p < w * h; p++) begin
				r = rand_word();
				write_reg(reg_addr(REG_PIXEL, p), {24'd0, r[7:0]});
			end
			for (int k = 0; k < N_CH * N_TAPS; k++) begin
				r = rand_word();
				if (!big_weights) begin
					wv = int'($signed(r[7:0]));
				end else if ((k / N_TAPS) % 2 == 0) begin
					wv = 100 + int'(r % 28);
				end else begin
					wv = -128 + int'(r % 28);
				end
				write_reg(reg_addr(REG_WEIGHT, k), 32'(wv) & 32'hff);
			end
			for (int ch = 0; ch < N_CH; ch++) begin
				r = rand_word();
				write_reg(reg_addr(REG_BIAS, ch), {16'd0, r[15:0]});
			end
			write_reg(reg_addr(REG_START, 0), 32'd1);
			read_reg(reg_addr(REG_DONE, 0), rd);
			check_word("REG_DONE after START", rd, 32'd0);
			wait_done();
		end
	endtask

	initial begin
		repeat (10) @(posedge clk);
		@(negedge clk);
		rstn = 1'b1;
		run_frame(8, 6, 1'b0, 6 + int'(rand_word() % 4), 1'b0, 1'b0);
		// Large weights push both channels into saturation
		run_frame(7, 5, 1'b1, 3, 1'b1, 1'b1);
		run_frame(4, 9, 1'b0, 7, 1'b0, 1'b1);
		repeat (4) @(negedge clk);
		if (!timed_out && compared != total_pixels) begin
			tb_other_errors++;
			$display("Compared %0d results but the frames held %0d pixels",
				compared, total_pixels);
		end
		$display("Results compared %0d, value errors %0d, other errors %0d",
			compared, tb_value_errors + value_errors, tb_other_errors + other_errors);
		if (tb_value_errors + value_errors == 0 && tb_other_errors + other_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
verilog/accel_bus_pkg.sv
verilog/accel_conv_pkg.sv
verilog/vr_stage.sv
verilog/ahb_reg_slave.sv
verilog/window_fetch.sv
verilog/conv3x3_mac.sv
verilog/cnn_accel_top.sv
test/conv_checker.sv
test/tb_cnn_accel.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
	--top-module tb_cnn_accel -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx '=== PASS ==='; then
	exit 0
fi
exit 1
